// ==== src/hsid_pkg.sv ====
package hsid_pkg;

  localparam int HSID_WORD_WIDTH        = 16;  // Band sample and error result
  localparam int HSID_DATA_WIDTH_MUL    = 32;  // Squared difference
  localparam int HSID_DATA_WIDTH_ACC    = 36;  // Error accumulator
  localparam int HSID_MSE_SHIFT         = 20;  // Keeps the top 16 accumulator bits
  localparam int HSID_HSP_BANDS_WIDTH   = 6;   // Band count, also captured FIFO depth 64
  localparam int HSID_HSP_LIBRARY_WIDTH = 6;   // Library size and reference index
  localparam int HSID_BUFFER_WIDTH      = 4;   // Reference FIFO holds 16 words

  // Reference words per run, bands times library size
  localparam int HSID_REF_WORDS_WIDTH = HSID_HSP_BANDS_WIDTH + HSID_HSP_LIBRARY_WIDTH;

  typedef enum logic [2:0] {
    IDLE,
    READ_HSP_CAPTURED,
    COMPUTE_MSE,
    WAIT_RESULT,
    DONE
  } hsid_main_state_t;

endpackage

// ==== src/hsid_fifo.sv ====
`timescale 1ns/1ps

module hsid_fifo #(
  parameter int FIFO_ADDR_WIDTH = 4
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 clear,
  input  logic                                 wr_en,
  input  logic                                 rd_en,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0] data_in,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0] data_out,
  output logic [FIFO_ADDR_WIDTH:0]             count,
  output logic                                 full,
  output logic                                 empty
);

  logic [hsid_pkg::HSID_WORD_WIDTH-1:0] mem [2**FIFO_ADDR_WIDTH];
  logic [FIFO_ADDR_WIDTH-1:0]           wr_ptr;
  logic [FIFO_ADDR_WIDTH-1:0]           rd_ptr;
  logic                                 wr_ok;
  logic                                 rd_ok;

  assign full     = count[FIFO_ADDR_WIDTH];  // Count reaches the depth
  assign empty    = (count == '0);
  assign wr_ok    = wr_en && !full;
  assign rd_ok    = rd_en && !empty;
  assign data_out = mem[rd_ptr];             // First word falls through

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Simultaneous read and write keep the level
      endcase
    end
  end

endmodule

// ==== src/hsid_main_fsm.sv ====
`timescale 1ns/1ps

module hsid_main_fsm (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        clear,
  input  logic                                        start,
  input  logic [hsid_pkg::HSID_HSP_BANDS_WIDTH-1:0]   hsp_bands,
  input  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] hsp_library_size,
  input  logic                                        band_data_in_valid,
  input  logic [hsid_pkg::HSID_HSP_BANDS_WIDTH:0]     fifo_captured_count,
  input  logic                                        fifo_ref_full,
  input  logic                                        fifo_ref_empty,
  input  logic                                        mse_comparison_valid,
  output hsid_pkg::hsid_main_state_t                  state,
  output logic                                        band_data_ready,
  output logic [hsid_pkg::HSID_HSP_BANDS_WIDTH-1:0]   cfg_hsp_bands,
  output logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] hsp_ref,
  output logic                                        band_pack_start,
  output logic                                        band_pack_last,
  output logic                                        band_pack_valid,
  output logic                                        fifo_both_read_en,
  output logic                                        initialize,
  output logic                                        done,
  output logic                                        idle,
  output logic                                        ready
);

  hsid_pkg::hsid_main_state_t                  state_next;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] cfg_library_size;
  logic [hsid_pkg::HSID_REF_WORDS_WIDTH-1:0]   ref_words_left;  // Reference words still to accept
  logic [hsid_pkg::HSID_HSP_BANDS_WIDTH-1:0]   band_idx;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] cmp_count;       // Finished comparisons
  logic                                        stream_accept;
  logic                                        capture_last;
  logic                                        ref_last;
  logic                                        cmp_last;

  assign idle  = (state == hsid_pkg::IDLE);
  assign ready = idle;
  assign done  = (state == hsid_pkg::DONE);  // DONE lasts exactly one cycle

  assign initialize = idle && start;  // Datapath clears on the accepting edge

  always_comb begin
    case (state)
      hsid_pkg::READ_HSP_CAPTURED: band_data_ready = 1'b1;
      hsid_pkg::COMPUTE_MSE:       band_data_ready = !fifo_ref_full && (ref_words_left != '0);
      default:                     band_data_ready = 1'b0;
    endcase
  end

  assign stream_accept = band_data_in_valid && band_data_ready;

  // Last captured word is written on this edge
  assign capture_last = stream_accept &&
                        ((fifo_captured_count + 1'b1) == {1'b0, cfg_hsp_bands});

  assign fifo_both_read_en = (state == hsid_pkg::COMPUTE_MSE) && !fifo_ref_empty;
  assign band_pack_valid   = fifo_both_read_en;
  assign band_pack_start   = (band_idx == '0);
  assign band_pack_last    = (band_idx == cfg_hsp_bands - 1'b1);

  assign ref_last = fifo_both_read_en && band_pack_last &&
                    (hsp_ref == cfg_library_size - 1'b1);
  assign cmp_last = mse_comparison_valid && (cmp_count == cfg_library_size - 1'b1);

  always_comb begin
    state_next = state;
    case (state)
      hsid_pkg::IDLE: begin
        if (start) begin
          state_next = hsid_pkg::READ_HSP_CAPTURED;
        end
      end
      hsid_pkg::READ_HSP_CAPTURED: begin
        if (capture_last) begin
          state_next = hsid_pkg::COMPUTE_MSE;
        end
      end
      hsid_pkg::COMPUTE_MSE: begin
        if (ref_last) begin
          state_next = hsid_pkg::WAIT_RESULT;
        end
      end
      hsid_pkg::WAIT_RESULT: begin
        if (cmp_last) begin
          state_next = hsid_pkg::DONE;
        end
      end
      default: state_next = hsid_pkg::IDLE;  // DONE returns to IDLE
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state            <= hsid_pkg::IDLE;
      cfg_hsp_bands    <= '0;
      cfg_library_size <= '0;
      ref_words_left   <= '0;
      band_idx         <= '0;
      hsp_ref          <= '0;
      cmp_count        <= '0;
    end else if (clear) begin
      state          <= hsid_pkg::IDLE;
      ref_words_left <= '0;
      band_idx       <= '0;
      hsp_ref        <= '0;
      cmp_count      <= '0;
    end else begin
      state <= state_next;
      if (initialize) begin
        cfg_hsp_bands    <= hsp_bands;
        cfg_library_size <= hsp_library_size;
        ref_words_left   <= hsp_bands * hsp_library_size;
        band_idx         <= '0;
        hsp_ref          <= '0;
        cmp_count        <= '0;
      end
      if (stream_accept && (state == hsid_pkg::COMPUTE_MSE)) begin
        ref_words_left <= ref_words_left - 1'b1;
      end
      if (fifo_both_read_en) begin
        if (band_pack_last) begin
          band_idx <= '0;
          hsp_ref  <= hsp_ref + 1'b1;  // Next reference starts at band 0
        end else begin
          band_idx <= band_idx + 1'b1;
        end
      end
      if (mse_comparison_valid) begin
        cmp_count <= cmp_count + 1'b1;
      end
    end
  end

endmodule

// ==== src/hsid_mse.sv ====
`timescale 1ns/1ps

module hsid_mse (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        clear,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        band_pack_a,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        band_pack_b,
  input  logic                                        band_pack_valid,
  input  logic                                        band_pack_start,
  input  logic                                        band_pack_last,
  input  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] hsp_ref,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_value,
  output logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_ref,
  output logic                                        mse_valid,
  output logic                                        acc_of
);

  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        diff;
  logic [hsid_pkg::HSID_DATA_WIDTH_MUL-1:0]    sq;
  logic                                        s1_valid;
  logic                                        s1_start;
  logic                                        s1_last;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] s1_ref;
  logic [hsid_pkg::HSID_DATA_WIDTH_MUL-1:0]    s1_sq;
  logic [hsid_pkg::HSID_DATA_WIDTH_ACC-1:0]    acc_run;
  logic [hsid_pkg::HSID_DATA_WIDTH_ACC-1:0]    acc_base;
  logic [hsid_pkg::HSID_DATA_WIDTH_ACC:0]      sum;       // Top bit is the carry out
  logic [hsid_pkg::HSID_DATA_WIDTH_ACC-1:0]    sum_shifted;
  logic                                        of_run;    // Sticky per reference
  logic                                        of_next;

  assign diff = (band_pack_a > band_pack_b) ? band_pack_a - band_pack_b
                                            : band_pack_b - band_pack_a;
  assign sq   = diff * diff;

  // A new reference restarts from zero instead of the running sum
  assign acc_base    = s1_start ? '0 : acc_run;
  assign sum         = acc_base + s1_sq;
  assign of_next     = (s1_start ? 1'b0 : of_run) | sum[hsid_pkg::HSID_DATA_WIDTH_ACC];
  assign sum_shifted = sum[hsid_pkg::HSID_DATA_WIDTH_ACC-1:0] >> hsid_pkg::HSID_MSE_SHIFT;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      mse_valid <= 1'b0;
      of_run    <= 1'b0;
    end else if (clear) begin
      s1_valid  <= 1'b0;
      mse_valid <= 1'b0;
      of_run    <= 1'b0;
    end else begin
      s1_valid  <= band_pack_valid;
      mse_valid <= s1_valid && s1_last;
      if (s1_valid) begin
        of_run <= of_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (band_pack_valid) begin
      s1_sq    <= sq;
      s1_start <= band_pack_start;
      s1_last  <= band_pack_last;
      s1_ref   <= hsp_ref;
    end
    if (clear) begin
      acc_run <= '0;
    end else if (s1_valid) begin
      acc_run <= sum[hsid_pkg::HSID_DATA_WIDTH_ACC-1:0];
    end
    if (s1_valid && s1_last) begin
      mse_value <= sum_shifted[hsid_pkg::HSID_WORD_WIDTH-1:0];
      mse_ref   <= s1_ref;
      acc_of    <= of_next;
    end
  end

endmodule

// ==== src/hsid_mse_comp.sv ====
`timescale 1ns/1ps

module hsid_mse_comp (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        clear,
  input  logic                                        mse_in_valid,
  input  logic                                        mse_in_of,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_in_value,
  input  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_in_ref,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_min_value,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_max_value,
  output logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_min_ref,
  output logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_max_ref,
  output logic                                        mse_out_valid
);

  logic take;

  assign take = mse_in_valid && !mse_in_of;  // Overflowed references are skipped

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mse_min_value <= '1;
      mse_max_value <= '0;
      mse_min_ref   <= '0;
      mse_max_ref   <= '0;
      mse_out_valid <= 1'b0;
    end else if (clear) begin
      mse_min_value <= '1;
      mse_max_value <= '0;
      mse_min_ref   <= '0;
      mse_max_ref   <= '0;
      mse_out_valid <= 1'b0;
    end else begin
      mse_out_valid <= mse_in_valid;
      // Strict compares keep the earlier index on a tie
      if (take && (mse_in_value < mse_min_value)) begin
        mse_min_value <= mse_in_value;
        mse_min_ref   <= mse_in_ref;
      end
      if (take && (mse_in_value > mse_max_value)) begin
        mse_max_value <= mse_in_value;
        mse_max_ref   <= mse_in_ref;
      end
    end
  end

endmodule

// ==== src/hsid_main.sv ====
`timescale 1ns/1ps

module hsid_main (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        clear,
  input  logic                                        start,
  input  logic                                        band_data_in_valid,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        band_data_in,
  input  logic [hsid_pkg::HSID_HSP_BANDS_WIDTH-1:0]   hsp_bands_in,
  input  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] hsp_library_size_in,
  output logic                                        band_data_ready,
  output logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_min_ref,
  output logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_max_ref,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_min_value,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_max_value,
  output logic                                        done,
  output logic                                        idle,
  output logic                                        ready
);

  hsid_pkg::hsid_main_state_t                  state;
  logic [hsid_pkg::HSID_HSP_BANDS_WIDTH:0]     fifo_captured_count;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        fifo_captured_data_in;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        fifo_captured_data_out;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        fifo_ref_data_out;
  logic                                        fifo_captured_write_en;
  logic                                        fifo_ref_write_en;
  logic                                        fifo_ref_full;
  logic                                        fifo_ref_empty;
  logic                                        fifo_both_read_en;
  logic                                        band_pack_start;
  logic                                        band_pack_last;
  logic                                        band_pack_valid;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] hsp_ref;
  logic                                        initialize;
  logic                                        datapath_clear;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_value;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_ref;
  logic                                        mse_valid;
  logic                                        acc_of;
  logic                                        mse_comparison_valid;
  logic                                        stream_accept;

  assign datapath_clear = clear || initialize;
  assign stream_accept  = band_data_in_valid && band_data_ready;

  // Capture takes the stream, compute loops the head back to replay the pixel
  assign fifo_captured_data_in  = (state == hsid_pkg::READ_HSP_CAPTURED) ? band_data_in
                                                                         : fifo_captured_data_out;
  assign fifo_captured_write_en = ((state == hsid_pkg::READ_HSP_CAPTURED) && stream_accept) ||
                                  fifo_both_read_en;
  assign fifo_ref_write_en      = (state == hsid_pkg::COMPUTE_MSE) && stream_accept;

  hsid_main_fsm i_hsid_main_fsm (
    .clk                 (clk),
    .arst_n              (arst_n),
    .clear               (clear),
    .start               (start),
    .hsp_bands           (hsp_bands_in),
    .hsp_library_size    (hsp_library_size_in),
    .band_data_in_valid  (band_data_in_valid),
    .fifo_captured_count (fifo_captured_count),
    .fifo_ref_full       (fifo_ref_full),
    .fifo_ref_empty      (fifo_ref_empty),
    .mse_comparison_valid(mse_comparison_valid),
    .state               (state),
    .band_data_ready     (band_data_ready),
    .cfg_hsp_bands       (),
    .hsp_ref             (hsp_ref),
    .band_pack_start     (band_pack_start),
    .band_pack_last      (band_pack_last),
    .band_pack_valid     (band_pack_valid),
    .fifo_both_read_en   (fifo_both_read_en),
    .initialize          (initialize),
    .done                (done),
    .idle                (idle),
    .ready               (ready)
  );

  hsid_fifo #(
    .FIFO_ADDR_WIDTH(hsid_pkg::HSID_HSP_BANDS_WIDTH)  // 64 words of captured pixel
  ) fifo_captured (
    .clk     (clk),
    .arst_n  (arst_n),
    .clear   (datapath_clear),
    .wr_en   (fifo_captured_write_en),
    .rd_en   (fifo_both_read_en),
    .data_in (fifo_captured_data_in),
    .data_out(fifo_captured_data_out),
    .count   (fifo_captured_count),
    .full    (),
    .empty   ()
  );

  hsid_fifo #(
    .FIFO_ADDR_WIDTH(hsid_pkg::HSID_BUFFER_WIDTH)  // Reference word buffer
  ) fifo_ref (
    .clk     (clk),
    .arst_n  (arst_n),
    .clear   (datapath_clear),
    .wr_en   (fifo_ref_write_en),
    .rd_en   (fifo_both_read_en),
    .data_in (band_data_in),
    .data_out(fifo_ref_data_out),
    .count   (),
    .full    (fifo_ref_full),
    .empty   (fifo_ref_empty)
  );

  hsid_mse i_hsid_mse (
    .clk            (clk),
    .arst_n         (arst_n),
    .clear          (datapath_clear),
    .band_pack_a    (fifo_captured_data_out),
    .band_pack_b    (fifo_ref_data_out),
    .band_pack_valid(band_pack_valid),
    .band_pack_start(band_pack_start),
    .band_pack_last (band_pack_last),
    .hsp_ref        (hsp_ref),
    .mse_value      (mse_value),
    .mse_ref        (mse_ref),
    .mse_valid      (mse_valid),
    .acc_of         (acc_of)
  );

  hsid_mse_comp i_hsid_mse_comp (
    .clk          (clk),
    .arst_n       (arst_n),
    .clear        (datapath_clear),
    .mse_in_valid (mse_valid),
    .mse_in_of    (acc_of),
    .mse_in_value (mse_value),
    .mse_in_ref   (mse_ref),
    .mse_min_value(mse_min_value),
    .mse_max_value(mse_max_value),
    .mse_min_ref  (mse_min_ref),
    .mse_max_ref  (mse_max_ref),
    .mse_out_valid(mse_comparison_valid)
  );

endmodule

// ==== testbench/hsid_main_assert.sv ====
`timescale 1ns/1ps

module hsid_main_assert (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       clear,
  input logic                       start,
  input hsid_pkg::hsid_main_state_t state,
  input logic                       band_data_ready,
  input logic                       done,
  input logic                       idle,
  input logic                       ready
);

  int unsigned fail_count = 0;  // Read by the testbench at the end of the run

  // An accepted start leaves IDLE for the capture
  start_leaves_idle: assert property (@(posedge clk) disable iff (!arst_n)
                                      (ready && start && !clear) |=>
                                      (!idle && (state == hsid_pkg::READ_HSP_CAPTURED)))
    else begin
      fail_count++;
      $error("start was accepted but the controller did not begin the capture");
    end

  done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  no_ready_in_idle: assert property (@(posedge clk) disable iff (!arst_n)
                                     (state == hsid_pkg::IDLE) |-> !band_data_ready)
    else begin
      fail_count++;
      $error("band_data_ready is high in IDLE");
    end

endmodule

bind hsid_main hsid_main_assert i_hsid_main_assert (
  .clk            (clk),
  .arst_n         (arst_n),
  .clear          (clear),
  .start          (start),
  .state          (state),
  .band_data_ready(band_data_ready),
  .done           (done),
  .idle           (idle),
  .ready          (ready)
);

// ==== testbench/hsid_main_tb.sv ====
`timescale 1ns/1ps

module hsid_main_tb;

  localparam int     CLK_PERIOD      = 100;
  localparam int     NUM_RUNS        = 10;
  localparam int     GAP_MAX         = 3;
  localparam longint WATCHDOG_CYCLES = NUM_RUNS * 64 * 64 * (GAP_MAX + 1) + 2000;
  localparam int     MODE_FULL       = 0;
  localparam int     MODE_SMALL      = 1;
  localparam int     MODE_TIE        = 2;
  localparam int     MODE_OVERFLOW   = 3;

  logic                                        clk = 1'b0;
  logic                                        arst_n;
  logic                                        clear;
  logic                                        start;
  logic                                        band_data_in_valid;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        band_data_in;
  logic [hsid_pkg::HSID_HSP_BANDS_WIDTH-1:0]   hsp_bands_in;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] hsp_library_size_in;
  logic                                        band_data_ready;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_min_ref;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] mse_max_ref;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_min_value;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        mse_max_value;
  logic                                        done;
  logic                                        idle;
  logic                                        ready;

  logic [15:0]                                 lfsr = 16'd60;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        words[$];  // Captured pixel, then references
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        exp_min_value;
  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]        exp_max_value;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] exp_min_ref;
  logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] exp_max_ref;
  int                                          checks = 0;
  int                                          errors = 0;

  hsid_main i_hsid_main (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);  // Taps 16 14 13 11
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int draw_gap(input int gap_max);
    return (gap_max == 0) ? 0 : int'(rand_bits(4)) % (gap_max + 1);
  endfunction

  task automatic check_value(input string name, input logic [hsid_pkg::HSID_WORD_WIDTH-1:0] exp,
                             input logic [hsid_pkg::HSID_WORD_WIDTH-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic check_ref(input string name,
                           input logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] exp,
                           input logic [hsid_pkg::HSID_HSP_LIBRARY_WIDTH-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic build_stimulus(input int bands, input int lib, input int mode);
    logic [hsid_pkg::HSID_WORD_WIDTH-1:0] w;
    words = {};
    for (int i = 0; i < bands * (lib + 1); i++) begin
      if (mode == MODE_OVERFLOW) begin
        w = (i < bands) ? 16'(rand_bits(8)) : (16'hff00 | 16'(rand_bits(8)));
      end else if (mode == MODE_TIE && i >= 3 * bands) begin
        w = words[i - 2 * bands];  // References alternate between two spectra
      end else if (mode == MODE_SMALL) begin
        w = 16'(rand_bits(8));
      end else begin
        w = 16'(rand_bits(16));
      end
      words.push_back(w);
    end
  endtask

  task automatic compute_expected(input int bands, input int lib);
    longint                               sum;
    longint                               d;
    logic [hsid_pkg::HSID_WORD_WIDTH-1:0] val;
    exp_min_value = '1;
    exp_max_value = '0;
    exp_min_ref   = '0;
    exp_max_ref   = '0;
    for (int r = 0; r < lib; r++) begin
      sum = 0;
      for (int b = 0; b < bands; b++) begin
        d = longint'(words[b]) - longint'(words[bands * (r + 1) + b]);
        sum += d * d;
      end
      if (sum < (longint'(1) << 36)) begin  // Sums past 36 bits are dropped
        val = 16'(sum >> 20);
        if (val < exp_min_value) begin
          exp_min_value = val;
          exp_min_ref   = 6'(r);
        end
        if (val > exp_max_value) begin
          exp_max_value = val;
          exp_max_ref   = 6'(r);
        end
      end
    end
  endtask

  task automatic start_run(input int bands, input int lib);
    do begin
      @(posedge clk);
    end while (!ready);
    start               <= 1'b1;
    hsp_bands_in        <= 6'(bands);
    hsp_library_size_in <= 6'(lib);
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic stream_words(input int n_words, input int gap_max);
    int idx;
    int gap;
    idx = 0;
    gap = draw_gap(gap_max);
    while (idx < n_words) begin
      @(posedge clk);
      if (band_data_in_valid && band_data_ready) begin
        idx++;
        gap = draw_gap(gap_max);
      end
      if (idx < n_words && gap == 0) begin
        band_data_in_valid <= 1'b1;  // Held until accepted
        band_data_in       <= words[idx];
      end else begin
        band_data_in_valid <= 1'b0;
        if (gap > 0) begin
          gap--;
        end
      end
    end
  endtask

  task automatic run_test(input string name, input int bands, input int lib, input int mode,
                          input int gap_max);
    build_stimulus(bands, lib, mode);
    compute_expected(bands, lib);
    start_run(bands, lib);
    stream_words(words.size(), gap_max);
    do begin
      @(negedge clk);
    end while (!done);
    check_value({name, " min value"}, exp_min_value, mse_min_value);
    check_value({name, " max value"}, exp_max_value, mse_max_value);
    check_ref({name, " min ref"}, exp_min_ref, mse_min_ref);
    check_ref({name, " max ref"}, exp_max_ref, mse_max_ref);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the DUT did not finish the runs in time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    arst_n              = 1'b0;
    clear               = 1'b0;
    start               = 1'b0;
    band_data_in_valid  = 1'b0;
    band_data_in        = '0;
    hsp_bands_in        = '0;
    hsp_library_size_in = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset idle", 1'b1, idle);
    check_flag("reset ready", 1'b1, ready);
    check_flag("reset done", 1'b0, done);
    check_flag("reset band_data_ready", 1'b0, band_data_ready);
    check_value("reset min value", '1, mse_min_value);
    check_value("reset max value", '0, mse_max_value);
    check_ref("reset min ref", '0, mse_min_ref);
    check_ref("reset max ref", '0, mse_max_ref);
    for (int i = 0; i < 4; i++) begin
      run_test($sformatf("random_%0d", i), int'(rand_bits(6) % 63) + 1,
               int'(rand_bits(6) % 63) + 1, (i % 2 == 0) ? MODE_FULL : MODE_SMALL, GAP_MAX);
    end
    run_test("tie", 16, 12, MODE_TIE, 1);
    run_test("all_overflow", 63, 8, MODE_OVERFLOW, 0);
    run_test("mixed_overflow", 63, 20, MODE_FULL, 1);
    run_test("one_band", 1, 63, MODE_FULL, GAP_MAX);
    build_stimulus(20, 10, MODE_FULL);  // Abandoned part way through the references
    start_run(20, 10);
    stream_words(80, 1);
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    check_flag("clear idle", 1'b1, idle);
    check_value("clear min value", '1, mse_min_value);
    run_test("after_clear", 24, 17, MODE_SMALL, 2);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             i_hsid_main.i_hsid_main_assert.fail_count);
    if (errors == 0 && i_hsid_main.i_hsid_main_assert.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
src/hsid_pkg.sv
src/hsid_fifo.sv
src/hsid_main_fsm.sv
src/hsid_mse.sv
src/hsid_mse_comp.sv
src/hsid_main.sv
testbench/hsid_main_assert.sv
testbench/hsid_main_tb.sv
